/* poly_eval.f */
design/poly_pkg.sv
design/req_ack_receiver.sv
design/operand_store.sv
design/point_evaluator.sv
design/batch_sequencer.sv
design/result_sender.sv
design/poly_eval_top.sv
tests/poly_eval_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the polynomial evaluator testbench with Verilator and runs it.
# The exit status is zero only when the simulation ends without a $fatal.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module poly_eval_tb -f poly_eval.f -o poly_eval_sim \
	&& ./obj_dir/poly_eval_sim \
	|| { echo "simulation build or run did not complete cleanly"; exit 1; }

exit 0

/* tests/poly_eval_tb.sv */
// testbench for the batch polynomial evaluator; runs a table of jobs and checks every result.
`timescale 1ns/10ps

module poly_eval_tb;

	import poly_pkg::*;

	localparam int timeout_cycles = 1000;
	localparam int row_count = 5;

	typedef struct packed {
		job_t                                  job;
		logic [sample_width-1:0]               first;
		logic [sample_width-1:0]               step;
		logic [max_degree:0][sample_width-1:0] coefs;
	} row_t;

	logic    clk;
	logic    rst;
	logic    load_req;
	logic    load_ack;
	load_t   load_data;
	logic    job_req;
	logic    job_ack;
	job_t    job_data;
	logic    res_req;
	logic    res_ack;
	result_t res_data;

	// shadow copies of the DUT memories.
	logic [sample_width-1:0] sample_model [sample_depth];
	logic [sample_width-1:0] coef_model [max_degree+1];
	row_t                    stim_rows [row_count];
	logic [31:0]             rng_state;
	int                      jobs_finished;
	int                      results_seen;

	poly_eval_top uut (
		.clk(clk), .rst(rst),
		.load_req(load_req), .load_ack(load_ack), .load_data(load_data),
		.job_req(job_req), .job_ack(job_ack), .job_data(job_data),
		.res_req(res_req), .res_ack(res_ack), .res_data(res_data)
	);

	always #10 clk = ~clk;

	// result words offered on the port.
	always @(posedge res_req)
		results_seen++;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	// one clock, then a little past the edge.
	task automatic next_cycle(inout int n, input string what);
		@(posedge clk);
		#1;
		n++;
		if (n > timeout_cycles)
			abort_run($sformatf("timeout while waiting for %s", what));
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// expected value, highest coefficient first.
	function automatic logic [result_width-1:0] horner_model(
		input logic [sample_width-1:0] x,
		input logic [degree_width-1:0] deg
	);
		logic [result_width-1:0] acc;
		acc = '0;
		for (int i = int'(deg); i >= 0; i--)
			acc = acc * {16'h0000, x} + {16'h0000, coef_model[i[2:0]]};
		return acc;
	endfunction

	task automatic check_result(input result_t got, input result_t exp);
		if (got !== exp)
			abort_run($sformatf(
				"CHECK FAILED at %0t: got index %0d last %0b value %h, expected %0d %0b %h",
				$time, got.index, got.last, got.value, exp.index, exp.last, exp.value));
	endtask

	task automatic check_count(input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("CHECK FAILED at %0t: job gave %0d results, expected %0d",
				$time, got, exp));
	endtask

	task automatic send_load(input load_t w);
		int n;
		load_data = w;
		load_req  = 1'b1;
		n = 0;
		while (load_ack !== 1'b1)
			next_cycle(n, "load_ack to rise");
		load_req = 1'b0;
		n = 0;
		while (load_ack !== 1'b0)
			next_cycle(n, "load_ack to fall");
		if (w.target)
			coef_model[w.addr[degree_width-1:0]] = w.data;
		else
			sample_model[w.addr] = w.data;
	endtask

	task automatic load_row(input row_t r);
		load_t w;
		for (int k = 0; k <= max_degree; k++)
		begin
			w.target = 1'b1;
			w.addr   = addr_width'(k);
			w.data   = r.coefs[k[2:0]];
			send_load(w);
		end
		// sample addresses wrap at the end of the buffer.
		for (int k = 0; k < int'(r.job.count); k++)
		begin
			w.target = 1'b0;
			w.addr   = r.job.base + addr_width'(k);
			w.data   = r.first + sample_width'(k) * r.step;
			send_load(w);
		end
	endtask

	task automatic send_job(input job_t j, input int need_done);
		int n;
		job_data = j;
		job_req  = 1'b1;
		n = 0;
		while (job_ack !== 1'b1)
			next_cycle(n, "job_ack to rise");
		if (jobs_finished < need_done)
			abort_run("job_ack rose before the previous batch delivered its last result");
		job_req = 1'b0;
		n = 0;
		while (job_ack !== 1'b0)
			next_cycle(n, "job_ack to fall");
	endtask

	task automatic collect_job(input job_t j);
		int      n;
		int      got;
		int      delay;
		logic    seen_last;
		result_t res;
		result_t exp;
		got = 0;
		seen_last = 1'b0;
		while (!seen_last && got < 32)
		begin
			n = 0;
			while (res_req !== 1'b1)
				next_cycle(n, "res_req to rise");
			res = res_data;
			exp.index = count_width'(got);
			exp.last  = (got == int'(j.count) - 1);
			exp.value = horner_model(sample_model[j.base + addr_width'(got)], j.degree);
			check_result(res, exp);
			// random back-pressure on the result port.
			rng_state = xorshift32(rng_state);
			delay = int'(rng_state % 32'd6);
			n = 0;
			repeat (delay)
				next_cycle(n, "ack delay");
			res_ack = 1'b1;
			n = 0;
			while (res_req !== 1'b0)
				next_cycle(n, "res_req to fall");
			res_ack = 1'b0;
			got++;
			seen_last = res.last;
		end
		jobs_finished++;
	endtask

	initial
	begin
		job_t empty_job;
		job_t second_job;
		int   base_done;
		int   results_before;
		clk       = 1'b0;
		rst       = 1'b0;
		load_req  = 1'b0;
		load_data = '0;
		job_req   = 1'b0;
		job_data  = '0;
		res_ack   = 1'b0;
		rng_state = 32'h1ed7_c3a4;
		jobs_finished = 0;
		results_seen  = 0;

		// job, first sample, sample step, coefficients 7 down to 0.
		stim_rows[0] = '{job: '{base: 8'd10, count: 5'd6, degree: 3'd3},
			first: 16'd3, step: 16'd5,
			coefs: {16'hdead, 16'hbeef, 16'h1111, 16'h2222, 16'd7, 16'd9, 16'd2, 16'd4}};
		stim_rows[1] = '{job: '{base: 8'd40, count: 5'd4, degree: 3'd0},
			first: 16'h1234, step: 16'h0f0f,
			coefs: {16'h7, 16'h6, 16'h5, 16'h4, 16'h3, 16'h2, 16'h1, 16'h00aa}};
		stim_rows[2] = '{job: '{base: 8'd250, count: 5'd10, degree: 3'd2},
			first: 16'd100, step: 16'd3,
			coefs: {16'h9, 16'h8, 16'h7, 16'h6, 16'h5, 16'd5, 16'd11, 16'd13}};
		stim_rows[3] = '{job: '{base: 8'd128, count: 5'd5, degree: 3'd7},
			first: 16'hfff0, step: 16'h0003,
			coefs: {16'hffff, 16'hfedc, 16'hba98, 16'h7654,
				16'h3210, 16'hf00f, 16'h8001, 16'hc3c3}};
		stim_rows[4] = '{job: '{base: 8'd60, count: 5'd12, degree: 3'd5},
			first: 16'h0400, step: 16'h0123,
			coefs: {16'h0, 16'h0, 16'h1357, 16'h2468,
				16'h0abc, 16'h00ff, 16'h8000, 16'h0042}};

		repeat (5) @(posedge clk);
		#1;
		rst = 1'b1;

		// ========================================
		// job table.
		// ========================================
		for (int i = 0; i < row_count; i++)
		begin
			load_row(stim_rows[i]);
			fork
				send_job(stim_rows[i].job, jobs_finished);
				collect_job(stim_rows[i].job);
			join
		end

		// ========================================
		// queued jobs, empty one in between.
		// ========================================
		load_row(stim_rows[0]);
		empty_job  = '{base: 8'd0, count: 5'd0, degree: 3'd1};
		second_job = '{base: 8'd40, count: 5'd3, degree: 3'd3};
		base_done  = jobs_finished;
		results_before = 0;
		fork
			begin
				send_job(stim_rows[0].job, base_done);
				send_job(empty_job, base_done + 1);
				results_before = results_seen;
				send_job(second_job, base_done + 1);
				// the empty job must not put anything on the port.
				check_count(results_seen - results_before, 0);
			end
			begin
				collect_job(stim_rows[0].job);
				collect_job(second_job);
			end
		join

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* design/poly_eval_top.sv */
// top level of the batch polynomial evaluator; load and job ports in, result port out.
`timescale 1ns/10ps

module poly_eval_top (
	input  logic              clk,
	input  logic              rst,
	input  logic              load_req,
	output logic              load_ack,
	input  poly_pkg::load_t   load_data,
	input  logic              job_req,
	output logic              job_ack,
	input  poly_pkg::job_t    job_data,
	output logic              res_req,
	input  logic              res_ack,
	output poly_pkg::result_t res_data
);

	import poly_pkg::*;

	load_t                   load_word;
	logic                    load_valid;
	job_t                    job_word;
	logic                    job_valid;
	logic                    seq_idle;
	logic                    eval_start;
	logic [addr_width-1:0]   eval_addr;
	logic [degree_width-1:0] eval_degree;
	logic [addr_width-1:0]   sample_addr;
	logic [sample_width-1:0] sample;
	logic [degree_width-1:0] coef_addr;
	logic [sample_width-1:0] coef;
	logic                    eval_done;
	logic [result_width-1:0] eval_value;
	logic                    tx_free;
	logic                    tx_send;
	result_t                 tx_result;

	// ========================================
	// input side.
	// ========================================
	req_ack_receiver #(.payload_t(load_t)) load_rx (
		.clk(clk), .rst(rst), .req(load_req), .data(load_data), .ready(1'b1),
		.ack(load_ack), .valid(load_valid), .payload(load_word)
	);

	req_ack_receiver #(.payload_t(job_t)) job_rx (
		.clk(clk), .rst(rst), .req(job_req), .data(job_data), .ready(seq_idle),
		.ack(job_ack), .valid(job_valid), .payload(job_word)
	);

	operand_store store (
		.clk(clk), .rst(rst), .wr_valid(load_valid), .wr(load_word),
		.sample_addr(sample_addr), .sample(sample),
		.coef_addr(coef_addr), .coef(coef)
	);

	// ========================================
	// processing and output side.
	// ========================================
	point_evaluator eval (
		.clk(clk), .rst(rst), .start(eval_start), .addr(eval_addr), .degree(eval_degree),
		.sample_addr(sample_addr), .sample(sample), .coef_addr(coef_addr), .coef(coef),
		.done(eval_done), .value(eval_value)
	);

	batch_sequencer seq (
		.clk(clk), .rst(rst), .job_valid(job_valid), .job(job_word), .idle(seq_idle),
		.start(eval_start), .eval_addr(eval_addr), .degree(eval_degree),
		.done(eval_done), .value(eval_value), .free(tx_free),
		.send(tx_send), .result(tx_result)
	);

	result_sender tx (
		.clk(clk), .rst(rst), .send(tx_send), .result(tx_result), .free(tx_free),
		.req(res_req), .ack(res_ack), .data(res_data)
	);

endmodule

/* design/result_sender.sv */
// four-phase req/ack sender; holds one result until the handshake has fully completed.
`timescale 1ns/10ps

module result_sender (
	input  logic              clk,
	input  logic              rst,
	input  logic              send,
	input  poly_pkg::result_t result,
	output logic              free,
	output logic              req,
	input  logic              ack,
	output poly_pkg::result_t data
);

	logic full;

	assign free = !full;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			full <= 1'b0;
			req  <= 1'b0;
		end
		else
		begin
			if (send && !full)
			begin
				full <= 1'b1;
				req  <= 1'b1;
			end
			else if (req && ack)
				req <= 1'b0;
			// ack back low ends the four phases.
			else if (full && !req && !ack)
				full <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (send && !full)
			data <= result;
	end

endmodule

/* design/batch_sequencer.sv */
// batch sequencer: runs the evaluator once per point of a job and hands each result to the sender.
`timescale 1ns/10ps

module batch_sequencer (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              job_valid,
	input  poly_pkg::job_t                    job,
	output logic                              idle,
	output logic                              start,
	output logic [poly_pkg::addr_width-1:0]   eval_addr,
	output logic [poly_pkg::degree_width-1:0] degree,
	input  logic                              done,
	input  logic [poly_pkg::result_width-1:0] value,
	input  logic                              free,
	output logic                              send,
	output poly_pkg::result_t                 result
);

	import poly_pkg::*;

	typedef enum logic [2:0] {
		s_idle,
		s_wait_free,
		s_start,
		s_wait_done,
		s_send
	} state_t;

	state_t                  state;
	job_t                    job_q;
	logic [count_width-1:0]  cnt;
	logic [result_width-1:0] value_q;
	logic                    last;

	// a new job waits until the last result has left the sender too.
	assign idle = (state == s_idle) && free;
	assign start = (state == s_start);
	assign send = (state == s_send);
	assign eval_addr = job_q.base + addr_width'(cnt);
	assign degree = job_q.degree;
	assign last = (cnt == job_q.count - 5'd1);

	assign result.index = cnt;
	assign result.last  = last;
	assign result.value = value_q;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= s_idle;
			cnt   <= '0;
		end
		else
		begin
			case (state)
				s_idle:
				begin
					cnt <= '0;
					if (job_valid)
						state <= s_wait_free;
				end
				s_wait_free:
				begin
					// empty job, nothing to send.
					if (job_q.count == '0)
						state <= s_idle;
					else if (free)
						state <= s_start;
				end
				s_start:
					state <= s_wait_done;
				s_wait_done:
				begin
					if (done)
						state <= s_send;
				end
				s_send:
				begin
					if (last)
						state <= s_idle;
					else
					begin
						cnt   <= cnt + 5'd1;
						state <= s_wait_free;
					end
				end
				default:
					state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (job_valid && state == s_idle)
			job_q <= job;
		if (done)
			value_q <= value;
	end

endmodule

/* design/point_evaluator.sv */
// Horner evaluation of one sample point; done follows start by degree+3 cycles.
`timescale 1ns/10ps

module point_evaluator (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              start,
	input  logic [poly_pkg::addr_width-1:0]   addr,
	input  logic [poly_pkg::degree_width-1:0] degree,
	output logic [poly_pkg::addr_width-1:0]   sample_addr,
	input  logic [poly_pkg::sample_width-1:0] sample,
	output logic [poly_pkg::degree_width-1:0] coef_addr,
	input  logic [poly_pkg::sample_width-1:0] coef,
	output logic                              done,
	output logic [poly_pkg::result_width-1:0] value
);

	import poly_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_fetch,
		s_step
	} state_t;

	state_t                  state;
	logic [addr_width-1:0]   addr_q;
	logic [degree_width-1:0] idx;
	logic [result_width-1:0] acc;

	assign sample_addr = addr_q;
	// during a step the next lower coefficient is already requested.
	assign coef_addr = (state == s_step) ? idx - 3'd1 : idx;
	assign value = acc;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state  <= s_idle;
			addr_q <= '0;
			idx    <= '0;
			acc    <= '0;
			done   <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				s_idle:
				begin
					if (start)
					begin
						addr_q <= addr;
						idx    <= degree;
						state  <= s_fetch;
					end
				end
				s_fetch:
				begin
					acc   <= '0;
					state <= s_step;
				end
				s_step:
				begin
					// acc * x + c, modulo 2^32.
					acc <= acc * result_width'(sample) + result_width'(coef);
					if (idx == '0)
					begin
						done  <= 1'b1;
						state <= s_idle;
					end
					else
						idx <= idx - 3'd1;
				end
				default:
					state <= s_idle;
			endcase
		end
	end

endmodule

/* design/operand_store.sv */
// sample buffer and coefficient table, written from load words and read one cycle after the address.
`timescale 1ns/10ps

module operand_store (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              wr_valid,
	input  poly_pkg::load_t                   wr,
	input  logic [poly_pkg::addr_width-1:0]   sample_addr,
	output logic [poly_pkg::sample_width-1:0] sample,
	input  logic [poly_pkg::degree_width-1:0] coef_addr,
	output logic [poly_pkg::sample_width-1:0] coef
);

	import poly_pkg::*;

	logic [sample_width-1:0] sample_mem [sample_depth];
	logic [sample_width-1:0] coef_mem [max_degree+1];

	// ========================================
	// write side.
	// ========================================
	always_ff @(posedge clk)
	begin
		if (wr_valid)
		begin
			if (wr.target)
				coef_mem[wr.addr[degree_width-1:0]] <= wr.data;
			else
				sample_mem[wr.addr] <= wr.data;
		end
	end

	// ========================================
	// read side.
	// ========================================
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			sample <= '0;
			coef   <= '0;
		end
		else
		begin
			sample <= sample_mem[sample_addr];
			coef   <= coef_mem[coef_addr];
		end
	end

endmodule

/* design/req_ack_receiver.sv */
// four-phase req/ack receiver that captures one payload of any type per handshake.
`timescale 1ns/10ps

module req_ack_receiver #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     req,
	input  payload_t data,
	input  logic     ready,
	output logic     ack,
	output logic     valid,
	output payload_t payload
);

	logic accept;

	// a new word is taken only while ack is low.
	assign accept = req && ready && !ack;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			ack   <= 1'b0;
			valid <= 1'b0;
		end
		else
		begin
			valid <= accept;
			if (accept)
				ack <= 1'b1;
			else if (!req)
				ack <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			payload <= data;
	end

endmodule

/* design/poly_pkg.sv */
// shared sizes and packed payload structs for the polynomial evaluator and its testbench.
package poly_pkg;

	// ========================================
	// sizes.
	// ========================================
	localparam int sample_width = 16;
	localparam int result_width = 32;
	localparam int sample_depth = 256;
	localparam int addr_width   = 8;
	localparam int max_degree   = 7;
	localparam int degree_width = 3;
	localparam int count_width  = 5;

	// ========================================
	// payloads.
	// ========================================

	// target 0 writes the sample buffer, 1 the coefficient table.
	typedef struct packed {
		logic                    target;
		logic [addr_width-1:0]   addr;
		logic [sample_width-1:0] data;
	} load_t;

	typedef struct packed {
		logic [addr_width-1:0]   base;
		logic [count_width-1:0]  count;
		logic [degree_width-1:0] degree;
	} job_t;

	// index is the position of the point within its job.
	typedef struct packed {
		logic [count_width-1:0]  index;
		logic                    last;
		logic [result_width-1:0] value;
	} result_t;

endpackage
